// File: common/kcpu_op_pkg.sv
// Opcode encodings and opcode class helpers for the execution unit
package kcpu_op_pkg;

    typedef logic [7:0] op_t;

    // Loads and tests
    localparam op_t LD8    = 8'h00, LD16   = 8'h01, TST8   = 8'h02, TST16  = 8'h03;
    // Add and subtract
    localparam op_t ADD8   = 8'h10, ADD16  = 8'h11, ADC8   = 8'h12, SUB8   = 8'h13;
    localparam op_t SUB16  = 8'h14, CMP8   = 8'h15, CMP16  = 8'h16, SBC8   = 8'h17;
    // Logic, including the flag register forms
    localparam op_t AND8   = 8'h20, BIT8   = 8'h21, EOR8   = 8'h22, OR8    = 8'h23;
    localparam op_t ANDCC  = 8'h24, ORCC   = 8'h25;
    // Single operand
    localparam op_t CLR8   = 8'h30, CLR16  = 8'h31, COM8   = 8'h32, NEG8   = 8'h33;
    localparam op_t NEG16  = 8'h34, INC8   = 8'h35, INC16  = 8'h36, DEC8   = 8'h37;
    localparam op_t DEC16  = 8'h38;
    // One-bit shifts and rotates
    localparam op_t LSR8   = 8'h40, LSR16  = 8'h41, ROR8   = 8'h42, ROR16  = 8'h43;
    localparam op_t ASR8   = 8'h44, ASR16  = 8'h45, ASL8   = 8'h46, ASL16  = 8'h47;
    localparam op_t ROL8   = 8'h48, ROL16  = 8'h49;
    // Multi-step shifts, count in opnd1[3:0]
    localparam op_t SHL16N = 8'h50, SHR16N = 8'h51;
    // Miscellaneous
    localparam op_t ABX    = 8'h60, DAA    = 8'h61, SEX    = 8'h62, MUL    = 8'h63;
    localparam op_t LMUL   = 8'h64, ABS8   = 8'h65, ABS16  = 8'h66, DIVXB  = 8'h67;

    // Width of the result that N and Z are taken from
    function automatic logic op_is_16(op_t op);
        case (op)
            LD16, TST16, ADD16, SUB16, CMP16,
            CLR16, NEG16, INC16, DEC16,
            LSR16, ROR16, ASR16, ASL16, ROL16,
            SHL16N, SHR16N,
            ABX, SEX, MUL, LMUL, ABS16, DIVXB: return 1'b1;
            default:                          return 1'b0;
        endcase
    endfunction

    function automatic logic op_sets_n(op_t op);
        return !(op inside {ABX, MUL, LMUL, DIVXB, ANDCC, ORCC});
    endfunction

    function automatic logic op_sets_z(op_t op);
        return !(op inside {ABX, ABS8, ABS16, ANDCC, ORCC});
    endfunction

    // Opcodes that take more than one cycle
    function automatic logic op_is_multi(op_t op);
        return op inside {SHL16N, SHR16N, DIVXB};
    endfunction

endpackage

// File: common/kcpu_cc_pkg.sv
// Data widths and condition-code layout shared by the execution unit
package kcpu_cc_pkg;

    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;
    localparam int CC_W   = 8;

    typedef logic [WORD_W-1:0] word_t;   // Accumulator D or index register
    typedef logic [BYTE_W-1:0] byte_t;   // Accumulator A or B
    typedef logic [CC_W-1:0]   cc_t;     // E F H I N Z V C

    // Condition-code bit positions
    localparam int CC_C = 0;   // Carry or borrow
    localparam int CC_V = 1;   // Signed overflow
    localparam int CC_Z = 2;   // Zero
    localparam int CC_N = 3;   // Negative
    localparam int CC_I = 4;   // IRQ mask
    localparam int CC_H = 5;   // Half carry
    localparam int CC_F = 6;   // FIRQ mask
    localparam int CC_E = 7;   // Entire state saved

endpackage

// File: alu/kcpu_div.sv
// Restoring 16-by-8 unsigned divider, one quotient bit per enabled cycle
`timescale 1ns/1ps

module kcpu_div import kcpu_cc_pkg::*; #(
    parameter int DIV_BITS = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  start,
    input  word_t dividend,
    input  byte_t divisor,
    output word_t quot,
    output byte_t rem,
    output logic  busy,
    output logic  v
);

    localparam int CNT_W = (DIV_BITS > 1) ? $clog2(DIV_BITS) : 1;

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] step_cnt;
    logic [8:0]       part;      // Partial remainder
    word_t            shreg;     // Dividend bits out at the top, quotient bits in at the bottom
    byte_t            dvsr;
    byte_t            dvd_hi;
    word_t            dvd_lo;
    logic [8:0]       trial;
    logic             fits;

    // With DIV_BITS below 16 the upper dividend bits seed the remainder
    assign dvd_hi = byte_t'(dividend >> DIV_BITS);
    assign dvd_lo = dividend << (WORD_W - DIV_BITS);

    assign trial = {part[7:0], shreg[WORD_W-1]};
    assign fits  = trial >= {1'b0, dvsr};   // Always true for a zero divisor

    assign quot = shreg;
    assign rem  = part[7:0];
    assign busy = (state == RUN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
            v        <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state    <= RUN;
                    step_cnt <= CNT_W'(DIV_BITS - 1);
                    v        <= (divisor == 8'd0);
                end
                RUN: if (cen) begin
                    if (step_cnt == '0)
                        state <= IDLE;
                    else
                        step_cnt <= step_cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A zero divisor ends with all-ones quotient and the dividend low byte as remainder
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            part  <= {1'b0, dvd_hi};
            shreg <= dvd_lo;
            dvsr  <= divisor;
        end else if (state == RUN && cen) begin
            part  <= fits ? trial - {1'b0, dvsr} : trial;
            shreg <= {shreg[WORD_W-2:0], fits};
        end
    end

    a_no_start_in_run: assert property (@(posedge clk) disable iff (rst)
        (state == RUN) |-> !start)
        else $error("divider start while running");

endmodule

// File: alu/kcpu_alu.sv
// Combinational ALU with flag generation, feeding and selecting the divider
`timescale 1ns/1ps

module kcpu_alu import kcpu_op_pkg::*, kcpu_cc_pkg::*; #(
    parameter int DIV_BITS = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  op_t   op,
    input  word_t opnd0,
    input  word_t opnd1,
    input  cc_t   cc_in,
    input  logic  div_go,
    output cc_t   cc_out,
    output word_t rslt,
    output word_t rslt_hi,
    output logic  div_busy
);

    logic        div_start;
    logic        div_v;
    word_t       div_quot;
    byte_t       div_rem;
    cc_t         cc_nx;
    logic        cin;        // Carry into ADC and SBC
    logic [8:0]  t9;
    logic [16:0] t17;
    logic [31:0] prod;
    byte_t       daa_adj;

    // Signed overflow of a + b, subtract passes ~b
    function automatic logic add_ovf(logic a, logic b, logic r);
        return (a & b & ~r) | (~a & ~b & r);
    endfunction

    assign div_start = div_go && (op == DIVXB);   // Divider loads on the launch cycle only
    assign cc_out    = cc_nx;

    kcpu_div #(
        .DIV_BITS (DIV_BITS)
    ) u_div (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (div_start),
        .dividend (opnd0),
        .divisor  (opnd1[7:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (div_busy),
        .v        (div_v)
    );

    always_comb begin
        cc_nx   = cc_in;
        rslt    = opnd0;   // Byte forms keep the upper byte
        rslt_hi = '0;
        cin     = 1'b0;
        t9      = '0;
        t17     = '0;
        prod    = '0;
        daa_adj = '0;
        case (op)
            LD8: begin
                rslt[7:0]   = opnd1[7:0];
                cc_nx[CC_V] = 1'b0;
            end
            LD16: begin
                rslt        = opnd1;
                cc_nx[CC_V] = 1'b0;
            end
            TST8, TST16: cc_nx[CC_V] = 1'b0;
            ADD8, ADC8: begin
                cin         = (op == ADC8) && cc_in[CC_C];
                t9          = {1'b0, opnd0[7:0]} + {1'b0, opnd1[7:0]} + {8'd0, cin};
                rslt[7:0]   = t9[7:0];
                cc_nx[CC_C] = t9[8];
                cc_nx[CC_V] = add_ovf(opnd0[7], opnd1[7], t9[7]);
                cc_nx[CC_H] = opnd0[4] ^ opnd1[4] ^ t9[4];
            end
            SUB8, CMP8, SBC8: begin
                cin         = (op == SBC8) && cc_in[CC_C];
                t9          = {1'b0, opnd0[7:0]} - {1'b0, opnd1[7:0]} - {8'd0, cin};
                rslt[7:0]   = t9[7:0];
                cc_nx[CC_C] = t9[8];   // Borrow
                cc_nx[CC_V] = add_ovf(opnd0[7], ~opnd1[7], t9[7]);
                cc_nx[CC_H] = opnd0[4] ^ opnd1[4] ^ t9[4];
            end
            ADD16: begin
                t17         = {1'b0, opnd0} + {1'b0, opnd1};
                rslt        = t17[15:0];
                cc_nx[CC_C] = t17[16];
                cc_nx[CC_V] = add_ovf(opnd0[15], opnd1[15], t17[15]);
            end
            SUB16, CMP16: begin
                t17         = {1'b0, opnd0} - {1'b0, opnd1};
                rslt        = t17[15:0];
                cc_nx[CC_C] = t17[16];
                cc_nx[CC_V] = add_ovf(opnd0[15], ~opnd1[15], t17[15]);
            end
            AND8, BIT8: begin
                rslt[7:0]   = opnd0[7:0] & opnd1[7:0];
                cc_nx[CC_V] = 1'b0;
            end
            EOR8: begin
                rslt[7:0]   = opnd0[7:0] ^ opnd1[7:0];
                cc_nx[CC_V] = 1'b0;
            end
            OR8: begin
                rslt[7:0]   = opnd0[7:0] | opnd1[7:0];
                cc_nx[CC_V] = 1'b0;
            end
            ANDCC: cc_nx = cc_in & opnd1[7:0];
            ORCC:  cc_nx = cc_in | opnd1[7:0];
            CLR8, CLR16: begin
                rslt        = (op == CLR8) ? {opnd0[15:8], 8'h00} : '0;
                cc_nx[CC_C] = 1'b0;
                cc_nx[CC_V] = 1'b0;
            end
            COM8: begin
                rslt[7:0]   = ~opnd0[7:0];
                cc_nx[CC_C] = 1'b1;
                cc_nx[CC_V] = 1'b0;
            end
            NEG8: begin
                t9          = 9'd0 - {1'b0, opnd0[7:0]};
                rslt[7:0]   = t9[7:0];
                cc_nx[CC_C] = t9[8];                 // Set unless operand was zero
                cc_nx[CC_V] = opnd0[7] & t9[7];      // Only 0x80 overflows
            end
            NEG16: begin
                t17         = 17'd0 - {1'b0, opnd0};
                rslt        = t17[15:0];
                cc_nx[CC_C] = t17[16];
                cc_nx[CC_V] = opnd0[15] & t17[15];
            end
            INC8: begin
                rslt[7:0]   = opnd0[7:0] + 8'd1;
                cc_nx[CC_V] = ~opnd0[7] & rslt[7];
            end
            INC16: begin
                rslt        = opnd0 + 16'd1;
                cc_nx[CC_V] = ~opnd0[15] & rslt[15];
            end
            DEC8: begin
                rslt[7:0]   = opnd0[7:0] - 8'd1;
                cc_nx[CC_V] = opnd0[7] & ~rslt[7];
            end
            DEC16: begin
                rslt        = opnd0 - 16'd1;
                cc_nx[CC_V] = opnd0[15] & ~rslt[15];
            end
            LSR8: begin
                rslt[7:0]   = {1'b0, opnd0[7:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            LSR16, SHR16N: begin                     // Multi-step form does one bit here
                rslt        = {1'b0, opnd0[15:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            ROR8: begin
                rslt[7:0]   = {cc_in[CC_C], opnd0[7:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            ROR16: begin
                rslt        = {cc_in[CC_C], opnd0[15:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            ASR8: begin
                rslt[7:0]   = {opnd0[7], opnd0[7:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            ASR16: begin
                rslt        = {opnd0[15], opnd0[15:1]};
                cc_nx[CC_C] = opnd0[0];
            end
            ASL8, ROL8: begin
                rslt[7:0]   = {opnd0[6:0], (op == ROL8) && cc_in[CC_C]};
                cc_nx[CC_C] = opnd0[7];
                cc_nx[CC_V] = opnd0[7] ^ opnd0[6];
            end
            ASL16, SHL16N, ROL16: begin
                rslt        = {opnd0[14:0], (op == ROL16) && cc_in[CC_C]};
                cc_nx[CC_C] = opnd0[15];
                cc_nx[CC_V] = opnd0[15] ^ opnd0[14];
            end
            ABX: rslt = {8'h00, opnd0[7:0]} + opnd1;   // B unsigned into X
            DAA: begin
                daa_adj[3:0] = (cc_in[CC_H] || opnd0[3:0] > 4'd9) ? 4'd6 : 4'd0;
                daa_adj[7:4] = (cc_in[CC_C] || opnd0[7:4] > 4'd9 ||
                                (opnd0[7:4] > 4'd8 && opnd0[3:0] > 4'd9)) ? 4'd6 : 4'd0;
                t9           = {1'b0, opnd0[7:0]} + {1'b0, daa_adj};
                rslt[7:0]    = t9[7:0];
                cc_nx[CC_C]  = cc_in[CC_C] | t9[8];
            end
            SEX: begin
                rslt        = {{8{opnd0[7]}}, opnd0[7:0]};
                cc_nx[CC_V] = 1'b0;
            end
            MUL: begin
                rslt        = opnd0[15:8] * opnd0[7:0];
                cc_nx[CC_C] = rslt[7];               // Rounding hint for the low byte
            end
            LMUL: begin
                prod        = opnd0 * opnd1;
                rslt        = prod[15:0];
                rslt_hi     = prod[31:16];
                cc_nx[CC_C] = prod[31];
            end
            ABS8: begin
                rslt[7:0]   = opnd0[7] ? 8'd0 - opnd0[7:0] : opnd0[7:0];
                cc_nx[CC_C] = 1'b0;
                cc_nx[CC_V] = 1'b0;
            end
            ABS16: begin
                rslt        = opnd0[15] ? 16'd0 - opnd0 : opnd0;
                cc_nx[CC_C] = 1'b0;
                cc_nx[CC_V] = 1'b0;
            end
            DIVXB: begin
                rslt        = div_quot;
                rslt_hi     = {8'h00, div_rem};
                cc_nx[CC_V] = div_v;                 // Divide by zero
            end
            default: rslt = opnd0;
        endcase

        if (op_sets_z(op))
            cc_nx[CC_Z] = op_is_16(op) ? (rslt == 16'd0) : (rslt[7:0] == 8'd0);
        if (op_sets_n(op))
            cc_nx[CC_N] = op_is_16(op) ? rslt[15] : rslt[7];
    end

endmodule

// File: hdl/kcpu_exec.sv
// Execution unit top: operand latches, CC register, shift sequencing and completion
`timescale 1ns/1ps

module kcpu_exec import kcpu_op_pkg::*, kcpu_cc_pkg::*; #(
    parameter int DIV_BITS = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  start,
    input  op_t   op,
    input  word_t opnd0,
    input  word_t opnd1,
    input  logic  cc_wr,
    input  cc_t   cc_wdata,
    output word_t rslt,
    output word_t rslt_hi,
    output cc_t   cc,
    output logic  busy,
    output logic  done
);

    op_t        op_r;
    op_t        alu_op;
    word_t      a_r;         // Working operand, rewritten by each shift step
    word_t      b_r;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_rslt;
    word_t      alu_rslt_hi;
    cc_t        alu_cc;
    logic       div_busy;
    logic [3:0] step_cnt;
    logic       go;
    logic       single;
    logic       zero_shift;
    logic       shift_step;
    logic       last_step;
    logic       div_end;
    logic       finish;
    logic       cc_upd;

    assign go         = start && !busy;
    assign single     = go && !op_is_multi(op);
    assign zero_shift = go && op_is_multi(op) && (op != DIVXB) && (opnd1[3:0] == 4'd0);
    assign shift_step = busy && cen && (op_r != DIVXB);
    assign last_step  = shift_step && (step_cnt == 4'd1);
    assign div_end    = busy && (op_r == DIVXB) && !div_busy;
    assign finish     = single || zero_shift || last_step || div_end;
    assign cc_upd     = (finish && !zero_shift) || shift_step;

    // Launch cycle bypasses the latches so single-step results land one edge later
    assign alu_op = go ? op    : op_r;
    assign alu_a  = go ? opnd0 : a_r;
    assign alu_b  = go ? opnd1 : b_r;

    kcpu_alu #(
        .DIV_BITS (DIV_BITS)
    ) u_alu (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (alu_op),
        .opnd0    (alu_a),
        .opnd1    (alu_b),
        .cc_in    (cc),
        .div_go   (go),
        .cc_out   (alu_cc),
        .rslt     (alu_rslt),
        .rslt_hi  (alu_rslt_hi),
        .div_busy (div_busy)
    );

    always_ff @(posedge clk) begin
        if (go) begin
            op_r <= op;
            a_r  <= opnd0;
            b_r  <= opnd1;
        end else if (shift_step) begin
            a_r  <= alu_rslt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
            rslt     <= '0;
            rslt_hi  <= '0;
            cc       <= '0;
        end else begin
            done <= finish;
            if (go && op_is_multi(op) && !zero_shift)
                busy <= 1'b1;
            else if (last_step || div_end)
                busy <= 1'b0;
            if (go)
                step_cnt <= opnd1[3:0];
            else if (shift_step)
                step_cnt <= step_cnt - 4'd1;
            if (finish) begin
                rslt    <= zero_shift ? opnd0 : alu_rslt;   // Zero count passes the operand
                rslt_hi <= zero_shift ? '0 : alu_rslt_hi;
            end
            if (cc_upd)
                cc <= alu_cc;
            else if (cc_wr)
                cc <= cc_wdata;   // Direct load loses to an operation
        end
    end

    a_done_not_busy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
        else $error("done and busy high together");

    a_start_ignored: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else $warning("start ignored while busy");

endmodule

// File: bench/kcpu_ref_model.svh
// Reference model of the execution unit, computing rslt, rslt_hi and cc per opcode
`ifndef KCPU_REF_MODEL_SVH
`define KCPU_REF_MODEL_SVH

// True when a signed result no longer fits the operand width
function automatic logic ovf(input int s, input logic w);
    if (w)
        return (s > 32767) || (s < -32768);
    return (s > 127) || (s < -128);
endfunction

// Byte results keep the upper byte of the first operand
function automatic word_t merge(input word_t a, input logic w, input int s);
    if (w)
        return s[15:0];
    return {a[15:8], s[7:0]};
endfunction

// One operation or one step of a multi-step shift
function automatic void ref_step(input op_t o, input word_t a, input word_t b, input cc_t ci,
                                 output word_t r, output word_t rh, output cc_t co);
    int          ua;
    int          ub;
    int          sa;
    int          sb;
    int          c;
    int          s;
    int          adj;
    logic [31:0] p;
    logic        w;
    w  = op_is_16(o);
    ua = w ? int'(a) : int'(a[7:0]);
    ub = w ? int'(b) : int'(b[7:0]);
    sa = w ? int'($signed(a)) : int'($signed(a[7:0]));
    sb = w ? int'($signed(b)) : int'($signed(b[7:0]));
    r  = a;
    rh = '0;
    co = ci;
    case (o)
        LD8, LD16: begin
            r = merge(a, w, ub);
            co[CC_V] = 1'b0;
        end
        TST8, TST16: co[CC_V] = 1'b0;
        ADD8, ADC8, ADD16: begin
            c = (o == ADC8) ? int'(ci[CC_C]) : 0;
            s = ua + ub + c;
            r = merge(a, w, s);
            co[CC_C] = w ? (s > 65535) : (s > 255);
            co[CC_V] = ovf(sa + sb + c, w);
            if (!w)
                co[CC_H] = (int'(a[3:0]) + int'(b[3:0]) + c) > 15;   // Low nibble carry
        end
        SUB8, CMP8, SBC8, SUB16, CMP16: begin
            c = (o == SBC8) ? int'(ci[CC_C]) : 0;
            s = ua - ub - c;
            r = merge(a, w, s);
            co[CC_C] = (s < 0);                                     // Borrow
            co[CC_V] = ovf(sa - sb - c, w);
            if (!w)
                co[CC_H] = int'(a[3:0]) < (int'(b[3:0]) + c);
        end
        AND8, BIT8, EOR8, OR8: begin
            s = (o == EOR8) ? (ua ^ ub) : (o == OR8) ? (ua | ub) : (ua & ub);
            r = merge(a, w, s);
            co[CC_V] = 1'b0;
        end
        ANDCC: co = ci & b[7:0];
        ORCC:  co = ci | b[7:0];
        CLR8, CLR16: begin
            r = merge(a, w, 0);
            co[CC_C] = 1'b0;
            co[CC_V] = 1'b0;
        end
        COM8: begin
            r = merge(a, w, 255 - ua);
            co[CC_C] = 1'b1;
            co[CC_V] = 1'b0;
        end
        NEG8, NEG16: begin
            r = merge(a, w, -ua);
            co[CC_C] = (ua != 0);
            co[CC_V] = ovf(-sa, w);
        end
        INC8, INC16: begin
            r = merge(a, w, ua + 1);
            co[CC_V] = ovf(sa + 1, w);
        end
        DEC8, DEC16: begin
            r = merge(a, w, ua - 1);
            co[CC_V] = ovf(sa - 1, w);
        end
        LSR8, LSR16, SHR16N: begin
            r = merge(a, w, ua >> 1);
            co[CC_C] = a[0];
        end
        ROR8, ROR16: begin
            s = (ua >> 1) + (ci[CC_C] ? (w ? 32768 : 128) : 0);   // Old C into the top
            r = merge(a, w, s);
            co[CC_C] = a[0];
        end
        ASR8, ASR16: begin
            r = merge(a, w, sa >>> 1);
            co[CC_C] = a[0];
        end
        ASL8, ROL8, ASL16, ROL16, SHL16N: begin
            c = (o == ROL8 || o == ROL16) ? int'(ci[CC_C]) : 0;
            r = merge(a, w, ua * 2 + c);
            co[CC_C] = w ? a[15] : a[7];
            co[CC_V] = ovf(sa * 2 + c, w);
        end
        ABX: begin
            s = int'(a[7:0]) + int'(b);
            r = s[15:0];
        end
        DAA: begin
            adj = 0;
            if (ci[CC_H] || a[3:0] > 4'd9)
                adj = adj + 6;
            if (ci[CC_C] || a[7:4] > 4'd9 || (a[7:4] > 4'd8 && a[3:0] > 4'd9))
                adj = adj + 96;   // Upper digit correction
            s = int'(a[7:0]) + adj;
            r = merge(a, 1'b0, s);
            co[CC_C] = ci[CC_C] | (s > 255);
        end
        SEX: begin
            r = merge(a, 1'b1, int'($signed(a[7:0])));
            co[CC_V] = 1'b0;
        end
        MUL: begin
            s = int'(a[15:8]) * int'(a[7:0]);
            r = s[15:0];
            co[CC_C] = r[7];
        end
        LMUL: begin
            p  = {16'd0, a} * {16'd0, b};
            r  = p[15:0];
            rh = p[31:16];
            co[CC_C] = p[31];
        end
        ABS8, ABS16: begin
            r = merge(a, w, (sa < 0) ? -sa : sa);
            co[CC_C] = 1'b0;
            co[CC_V] = 1'b0;
        end
        DIVXB: begin   // Full 16-bit quotient
            if (b[7:0] == 8'd0) begin
                r  = 16'hffff;
                rh = {8'h00, a[7:0]};
                co[CC_V] = 1'b1;
            end else begin
                r  = a / {8'h00, b[7:0]};
                rh = a % {8'h00, b[7:0]};
                co[CC_V] = 1'b0;
            end
        end
        default: r = a;
    endcase
    // Z stays for ABX, ABS and the CC logic forms
    if (!(o inside {ABX, ABS8, ABS16, ANDCC, ORCC}))
        co[CC_Z] = w ? (r == 16'd0) : (r[7:0] == 8'd0);
    // N stays for ABX, the multiplies, the divide and the CC logic forms
    if (!(o inside {ABX, MUL, LMUL, DIVXB, ANDCC, ORCC}))
        co[CC_N] = w ? r[15] : r[7];
endfunction

// Whole operation that loops the one-bit step for the multi-step shifts
function automatic void ref_exec(input op_t o, input word_t a, input word_t b, input cc_t ci,
                                 output word_t r, output word_t rh, output cc_t co);
    word_t wr;
    word_t wh;
    cc_t   wc;
    int    n;
    if (o == SHL16N || o == SHR16N) begin
        r  = a;
        rh = '0;
        co = ci;
        for (n = 0; n < int'(b[3:0]); n++) begin
            ref_step(o, r, b, co, wr, wh, wc);
            r  = wr;
            co = wc;
        end
    end else begin
        ref_step(o, a, b, ci, r, rh, co);
    end
endfunction

`endif

// File: bench/kcpu_exec_tb.sv
// Self-checking testbench for the execution unit against a reference model
`timescale 1ns/1ps

module kcpu_exec_tb
    import kcpu_op_pkg::*, kcpu_cc_pkg::*;
();

    localparam int DIV_BITS    = 16;
    localparam int NUM_SINGLE  = 44;
    localparam int NUM_OPS     = 2 * NUM_SINGLE + 8 + 32 + 16;   // Two rounds, carry, shifts, divide
    localparam int CYCLE_LIMIT = NUM_OPS * (DIV_BITS * 8 + 20);

    localparam op_t SINGLE_OPS [NUM_SINGLE] = '{
        LD8, LD16, TST8, TST16, ADD8, ADD16, ADC8, SUB8, SUB16, CMP8, CMP16, SBC8,
        AND8, BIT8, EOR8, OR8, ANDCC, ORCC, CLR8, CLR16, COM8, NEG8, NEG16, INC8,
        INC16, DEC8, DEC16, LSR8, LSR16, ROR8, ROR16, ASR8, ASR16, ASL8, ASL16, ROL8,
        ROL16, ABX, DAA, SEX, MUL, LMUL, ABS8, ABS16
    };

    localparam op_t CARRY_OPS [4] = '{ADC8, SBC8, ROR8, ROL8};

    logic        clk;
    logic        rst;
    logic        cen;
    logic        start;
    op_t         op;
    word_t       opnd0;
    word_t       opnd1;
    logic        cc_wr;
    cc_t         cc_wdata;
    word_t       rslt;
    word_t       rslt_hi;
    cc_t         cc;
    logic        busy;
    logic        done;

    logic [15:0] lfsr_state = 16'd50;
    cc_t         model_cc;                // Model's own copy of the CC register
    op_t         exp_op[$];
    word_t       exp_rslt[$];
    word_t       exp_hi[$];
    cc_t         exp_cc[$];
    int          n_checked = 0;
    int          n_cycles  = 0;

    `include "kcpu_ref_model.svh"

    kcpu_exec #(
        .DIV_BITS (DIV_BITS)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (start),
        .op       (op),
        .opnd0    (opnd0),
        .opnd1    (opnd1),
        .cc_wr    (cc_wr),
        .cc_wdata (cc_wdata),
        .rslt     (rslt),
        .rslt_hi  (rslt_hi),
        .cc       (cc),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        n_cycles++;
        if (n_cycles >= CYCLE_LIMIT) begin
            $display("timeout at %0t: done never arrived within %0d cycles", $time, CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "wrong word value");
        end
    endtask

    task automatic check_cc(input cc_t got, input cc_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b (EFHINZVC)", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "wrong condition codes");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "wrong status bit");
        end
    endtask

    // Compares every completed operation with the model
    always @(negedge clk) begin
        if (!rst && done) begin
            if (exp_cc.size() == 0) begin
                $display("done pulsed at %0t with no operation outstanding", $time);
                $display("TEST FAILED");
                $fatal(1, "unexpected done");
            end
            check_word(rslt, exp_rslt.pop_front(), $sformatf("op %h rslt", exp_op[0]));
            check_word(rslt_hi, exp_hi.pop_front(), $sformatf("op %h rslt_hi", exp_op[0]));
            check_cc(cc, exp_cc.pop_front(), $sformatf("op %h cc", exp_op[0]));
            void'(exp_op.pop_front());
            n_checked++;
        end
    end

    // Next rising edge with a fresh cen that is high three times in four
    task automatic step_clock();
        @(posedge clk);
        cen <= (rand_bits(2) != 16'd0);
    endtask

    task automatic load_cc(input cc_t v);
        step_clock();
        cc_wr    <= 1'b1;
        cc_wdata <= v;
        step_clock();
        cc_wr    <= 1'b0;
        model_cc = v;
    endtask

    // Waits for done and sends a stray start on cycle number stray unless it is negative
    task automatic wait_done(input int stray);
        int k;
        k = 0;
        @(negedge clk);
        while (!done) begin
            check_bit(busy, 1'b1, "busy while an operation runs");
            step_clock();
            start <= (k == stray);
            if (k == stray) begin
                op    <= LD16;
                opnd0 <= rand_bits(16);
                opnd1 <= rand_bits(16);
            end
            k++;
            @(negedge clk);
        end
        check_bit(busy, 1'b0, "busy together with done");
    endtask

    task automatic run_op(input op_t o, input word_t a, input word_t b, input int stray);
        word_t r;
        word_t rh;
        cc_t   c;
        logic  one_cycle;
        one_cycle = (o != DIVXB) && !((o == SHL16N || o == SHR16N) && b[3:0] != 4'd0);
        ref_exec(o, a, b, model_cc, r, rh, c);
        exp_op.push_back(o);
        exp_rslt.push_back(r);
        exp_hi.push_back(rh);
        exp_cc.push_back(c);
        model_cc = c;
        step_clock();
        op    <= o;
        opnd0 <= a;
        opnd1 <= b;
        start <= 1'b1;
        step_clock();
        start <= 1'b0;
        if (one_cycle) begin
            @(negedge clk);
            check_bit(done, 1'b1, "done one cycle after start");
            check_bit(busy, 1'b0, "busy on a one-cycle operation");
        end else begin
            wait_done(stray);
        end
    endtask

    initial begin
        cc_t   v;
        byte_t d;
        word_t opa;
        word_t opb;
        int    i;
        int    j;
        rst      <= 1'b1;
        cen      <= 1'b0;
        start    <= 1'b0;
        op       <= LD8;
        opnd0    <= '0;
        opnd1    <= '0;
        cc_wr    <= 1'b0;
        cc_wdata <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_cc(cc, '0, "cc after reset");
        check_word(rslt, '0, "rslt after reset");
        check_word(rslt_hi, '0, "rslt_hi after reset");
        model_cc = '0;

        for (j = 0; j < 2; j++) begin
            for (i = 0; i < NUM_SINGLE; i++) begin
                load_cc(cc_t'(rand_bits(8)));
                run_op(SINGLE_OPS[i], rand_bits(16), rand_bits(16), -1);
            end
        end

        // Loaded carry must feed ADC, SBC and the rotates
        for (i = 0; i < 8; i++) begin
            v       = cc_t'(rand_bits(8));
            v[CC_C] = i[0];
            load_cc(v);
            run_op(CARRY_OPS[i / 2], rand_bits(16), rand_bits(16), -1);
        end

        for (i = 0; i < 32; i++) begin
            load_cc(cc_t'(rand_bits(8)));
            opa      = rand_bits(16);
            opb      = rand_bits(12) << 4;
            opb[3:0] = 4'(i / 2);
            run_op(i[0] ? SHR16N : SHL16N, opa, opb, -1);
        end

        for (i = 0; i < 16; i++) begin
            d = '0;
            if (i >= 2) begin
                while (d == 8'd0)
                    d = byte_t'(rand_bits(8));
            end
            load_cc(cc_t'(rand_bits(8)));
            run_op(DIVXB, rand_bits(16), {byte_t'(rand_bits(8)), d}, i[0] ? -1 : 1);
        end

        repeat (2) step_clock();
        if (n_checked != NUM_OPS) begin
            $display("only %0d of %0d results were checked", n_checked, NUM_OPS);
            $display("TEST FAILED");
            $fatal(1, "results missing");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+bench
common/kcpu_op_pkg.sv
common/kcpu_cc_pkg.sv
alu/kcpu_div.sv
alu/kcpu_alu.sv
hdl/kcpu_exec.sv
bench/kcpu_exec_tb.sv

// File: Bender.yml
package:
  name: kcpu_exec

sources:
  - files:
      - common/kcpu_op_pkg.sv
      - common/kcpu_cc_pkg.sv
      - alu/kcpu_div.sv
      - alu/kcpu_alu.sv
      - hdl/kcpu_exec.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/kcpu_exec_tb.sv
